// File: Makefile
# Verilator build, run and lint for the GPIO block testbench

VERILATOR ?= verilator
TOP       := gpioBlockTb
FILELIST  := list.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/gpioBlockTb.sv
// GPIO block testbench
// Clock, reset, stimulus table applied in a loop, timeout and summary

`timescale 1ns/1ps

module gpioBlockTb;

	localparam int pinCount = 16;
	localparam int maxRows  = 40;

	// Short names for the table rows
	localparam usiPkg::usiField_t wr   = usiPkg::cmdWrite;
	localparam usiPkg::usiField_t rd   = usiPkg::cmdRead;
	localparam usiPkg::usiField_t idle = usiPkg::cmdIdle;
	localparam usiPkg::usiField_t blk  = 8'h01;

	typedef logic [pinCount-1:0] pins_t;

	// One stimulus row and its hold time
	typedef struct {
		string             name;
		usiPkg::usiField_t cmd;
		usiPkg::usiField_t blkAdrs;
		gpioPkg::csrAdrs_t offset;
		usiPkg::usiWord_t  wd;
		pins_t             gpioIn;
		pins_t             altMode;
		int                hold;
	} stimRow_t;

	logic             iSCLK = 1'b0;
	logic             reset;
	usiPkg::usiWord_t iSUsiAdrs;
	usiPkg::usiWord_t iSUsiWd;
	usiPkg::usiWord_t oSUsiRd;
	pins_t            iGpioIn;
	pins_t            iGpioAltMode;
	pins_t            oGpioR;
	pins_t            oGpioDir;

	stimRow_t stimTable [maxRows];
	int       rowCount    = 0;
	int       cycleCount  = 0;
	int       cycleLimit  = 0;
	int       testsFailed = 0;

	gpioBlock dut_i (
		.iSCLK(iSCLK), .reset(reset), .iSUsiAdrs(iSUsiAdrs), .iSUsiWd(iSUsiWd),
		.oSUsiRd(oSUsiRd), .iGpioIn(iGpioIn), .iGpioAltMode(iGpioAltMode),
		.oGpioR(oGpioR), .oGpioDir(oGpioDir)
	);

	gpioChecker chk_i (
		.iSCLK(iSCLK), .reset(reset), .iSUsiAdrs(iSUsiAdrs), .iSUsiWd(iSUsiWd),
		.oSUsiRd(oSUsiRd), .iGpioIn(iGpioIn), .iGpioAltMode(iGpioAltMode),
		.oGpioR(oGpioR), .oGpioDir(oGpioDir)
	);

	// 100 ns period
	always #50 iSCLK = ~iSCLK;

	// Run limit from the table length
	always @(posedge iSCLK)
	begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit)
		begin
			$display("Timeout after %0d cycles, the test loop did not finish", cycleCount);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	//--------------------------------------------------------------------------
	// Table building and driving
	//--------------------------------------------------------------------------
	function automatic pins_t randPins();
		return pins_t'($urandom());
	endfunction

	task automatic addRow(input string name, input usiPkg::usiField_t cmd,
		input usiPkg::usiField_t blkAdrs, input gpioPkg::csrAdrs_t offset,
		input usiPkg::usiWord_t wd, input pins_t gpioIn, input pins_t altMode,
		input int hold);
		stimTable[rowCount] = '{name, cmd, blkAdrs, offset, wd, gpioIn, altMode, hold};
		rowCount++;
	endtask

	// Bits 15:8 carry junk, the block must ignore them
	task automatic applyRow(input stimRow_t row);
		iSUsiAdrs    = {row.blkAdrs, row.cmd, 8'ha5, row.offset};
		iSUsiWd      = row.wd;
		iGpioIn      = row.gpioIn;
		iGpioAltMode = row.altMode;
	endtask

	// Pins stay as the row set them
	task automatic driveIdle();
		iSUsiAdrs = '0;
		iSUsiWd   = '0;
	endtask

	task automatic buildTable();
		pins_t g1;
		pins_t g2;
		g1 = randPins();
		g2 = randPins();
		// Reset values
		addRow("rdOutReset", rd, blk, gpioPkg::adrsOut, 32'h0, 16'h0, randPins(), 4);
		addRow("rdDirReset", rd, blk, gpioPkg::adrsDir, 32'h0, 16'h0, randPins(), 4);
		addRow("rdAltReset", rd, blk, gpioPkg::adrsAlt, 32'h0, 16'h0, randPins(), 4);
		addRow("rdInReset", rd, blk, gpioPkg::adrsIn, 32'h0, 16'h0, randPins(), 4);
		addRow("rdSetReset", rd, blk, gpioPkg::adrsSet, 32'h0, 16'h0, randPins(), 4);
		addRow("rdClrReset", rd, blk, gpioPkg::adrsClr, 32'h0, 16'h0, randPins(), 4);
		// Read/write registers, upper half truncated
		addRow("wrOut", wr, blk, gpioPkg::adrsOut, 32'hdead_a5c3, 16'h0, randPins(), 4);
		addRow("rdOut", rd, blk, gpioPkg::adrsOut, 32'h0, 16'h0, randPins(), 4);
		addRow("wrDir", wr, blk, gpioPkg::adrsDir, 32'h1234_0ff0, 16'h0, randPins(), 4);
		addRow("rdDir", rd, blk, gpioPkg::adrsDir, 32'h0, 16'h0, randPins(), 4);
		// Set and clear
		addRow("wrSet", wr, blk, gpioPkg::adrsSet, 32'hffff_0f00, 16'h0, randPins(), 4);
		addRow("rdOutSet", rd, blk, gpioPkg::adrsOut, 32'h0, 16'h0, randPins(), 4);
		addRow("wrClr", wr, blk, gpioPkg::adrsClr, 32'h0000_0083, 16'h0, randPins(), 4);
		addRow("rdOutClr", rd, blk, gpioPkg::adrsOut, 32'h0, 16'h0, randPins(), 4);
		addRow("rdSet", rd, blk, gpioPkg::adrsSet, 32'h0, 16'h0, randPins(), 4);
		addRow("rdClr", rd, blk, gpioPkg::adrsClr, 32'h0, 16'h0, randPins(), 4);
		// Alternate function on the low byte
		addRow("wrAlt", wr, blk, gpioPkg::adrsAlt, 32'h0000_00ff, 16'h0, randPins(), 4);
		addRow("altPins1", idle, blk, gpioPkg::adrsOut, 32'h0, 16'h0, randPins(), 4);
		addRow("altPins2", idle, blk, gpioPkg::adrsOut, 32'h0, 16'h0, randPins(), 4);
		addRow("rdAlt", rd, blk, gpioPkg::adrsAlt, 32'h0, 16'h0, randPins(), 4);
		// Input held, then read
		addRow("inHold1", idle, blk, gpioPkg::adrsIn, 32'h0, g1, randPins(), 4);
		addRow("rdIn1", rd, blk, gpioPkg::adrsIn, 32'h0, g1, randPins(), 4);
		addRow("inHold2", idle, blk, gpioPkg::adrsIn, 32'h0, g2, randPins(), 4);
		addRow("rdIn2", rd, blk, gpioPkg::adrsIn, 32'h0, g2, randPins(), 4);
		// Commands the block must ignore
		addRow("wrForeign", wr, 8'h02, gpioPkg::adrsOut, 32'h0, g2, randPins(), 4);
		addRow("wrIdleCode", idle, blk, gpioPkg::adrsOut, 32'h0, g2, randPins(), 4);
		addRow("wrUnknown", 8'h07, blk, gpioPkg::adrsOut, 32'h0, g2, randPins(), 4);
		addRow("wrUnmapped", wr, blk, 8'h06, 32'h0000_ffff, g2, randPins(), 4);
		addRow("rdUnmapped", rd, blk, 8'h40, 32'h0, g2, randPins(), 4);
		addRow("rdForeign", rd, 8'h02, gpioPkg::adrsOut, 32'h0, g2, randPins(), 4);
		addRow("rdOutFinal", rd, blk, gpioPkg::adrsOut, 32'h0, g2, randPins(), 4);
	endtask

	//--------------------------------------------------------------------------
	// Main sequence
	//--------------------------------------------------------------------------
	initial
	begin
		int errBefore;
		int newErrs;
		reset        = 1'b1;
		iSUsiAdrs    = '0;
		iSUsiWd      = '0;
		iGpioIn      = '0;
		iGpioAltMode = '0;
		void'($urandom(32'h9e49));
		buildTable();
		cycleLimit = 6 * rowCount + 20;
		// Two reset cycles
		repeat (2) @(posedge iSCLK);
		#1;
		reset = 1'b0;
		for (int i = 0; i < rowCount; i++)
		begin
			errBefore = chk_i.errCount;
			@(posedge iSCLK);
			#1;
			applyRow(stimTable[i]);
			repeat (stimTable[i].hold)
			begin
				@(posedge iSCLK);
				#1;
				driveIdle();
			end
			newErrs = chk_i.errCount - errBefore;
			if (newErrs == 0)
				$display("%s: ok", stimTable[i].name);
			else
			begin
				testsFailed++;
				$display("%s: %0d mismatches", stimTable[i].name, newErrs);
			end
		end
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
			rowCount, rowCount - testsFailed, testsFailed, chk_i.errCount);
		if (testsFailed == 0 && chk_i.errCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: bench/gpioChecker.sv
// GPIO block checker
// Register and pipeline model from the bus and pin rules, output comparison

`timescale 1ns/1ps

module gpioChecker #(
	parameter usiPkg::usiField_t pBlockAdrs = 8'h01,
	parameter int                pGpioWidth = 16
)(
	input logic                  iSCLK,
	input logic                  reset,
	input usiPkg::usiWord_t      iSUsiAdrs,
	input usiPkg::usiWord_t      iSUsiWd,
	input usiPkg::usiWord_t      oSUsiRd,
	input logic [pGpioWidth-1:0] iGpioIn,
	input logic [pGpioWidth-1:0] iGpioAltMode,
	input logic [pGpioWidth-1:0] oGpioR,
	input logic [pGpioWidth-1:0] oGpioDir
);

	typedef logic [pGpioWidth-1:0] pinVec_t;

	// Mismatches so far, read by the testbench top
	int errCount = 0;
	// Set once the first reset edge is seen
	bit armed = 1'b0;

	// Access taken from the bus at the previous edge
	logic              accWrite;
	logic              accRead;
	gpioPkg::csrAdrs_t accAdrs;
	pinVec_t           accData;

	// Model of the registers and expected outputs
	pinVec_t           mOut;
	pinVec_t           mDir;
	pinVec_t           mAlt;
	pinVec_t           mIn;
	pinVec_t           sync1;
	pinVec_t           sync2;
	pinVec_t           expPins;
	usiPkg::usiWord_t  expRd;

	// Bus fields of the current cycle
	logic              blockMatch;
	usiPkg::usiField_t active;

	assign blockMatch = (iSUsiAdrs[usiPkg::blockMsb:usiPkg::blockLsb] == pBlockAdrs);
	assign active     = iSUsiAdrs[usiPkg::activeMsb:usiPkg::activeLsb];

	//--------------------------------------------------------------------------
	// Model update, one step per rising edge
	//--------------------------------------------------------------------------
	always @(posedge iSCLK)
	begin
		if (reset)
		begin
			accWrite = 1'b0;
			accRead  = 1'b0;
			accAdrs  = '0;
			accData  = '0;
			mOut     = '0;
			mDir     = '0;
			mAlt     = '0;
			mIn      = '0;
			sync1    = '0;
			sync2    = '0;
			expPins  = '0;
			expRd    = '0;
			armed    = 1'b1;
		end
		else
		begin
			// Pin register: alternate source as sampled now, else the old output value
			expPins = (mAlt & iGpioAltMode) | (~mAlt & mOut);
			// Read data from registers as they stood before this edge
			expRd = '0;
			if (accRead)
			begin
				case (accAdrs)
					gpioPkg::adrsOut: expRd[pGpioWidth-1:0] = mOut;
					gpioPkg::adrsDir: expRd[pGpioWidth-1:0] = mDir;
					gpioPkg::adrsAlt: expRd[pGpioWidth-1:0] = mAlt;
					gpioPkg::adrsIn:  expRd[pGpioWidth-1:0] = mIn;
					default:          expRd = '0;
				endcase
			end
			// Writes land one edge after the bus cycle
			if (accWrite)
			begin
				case (accAdrs)
					gpioPkg::adrsOut: mOut = accData;
					gpioPkg::adrsDir: mDir = accData;
					gpioPkg::adrsAlt: mAlt = accData;
					gpioPkg::adrsSet: mOut = mOut | accData;
					gpioPkg::adrsClr: mOut = mOut & ~accData;
					default:          ;
				endcase
			end
			// Two sync flops, then the input register
			mIn   = sync2;
			sync2 = sync1;
			sync1 = iGpioIn;
			// Current bus cycle, used at the next edge
			accWrite = blockMatch && (active == usiPkg::cmdWrite);
			accRead  = blockMatch && (active == usiPkg::cmdRead);
			accAdrs  = iSUsiAdrs[usiPkg::offsetMsb:usiPkg::offsetLsb];
			accData  = iSUsiWd[pGpioWidth-1:0];
		end
	end

	//--------------------------------------------------------------------------
	// Comparison at the falling edge, outputs settled
	//--------------------------------------------------------------------------
	task automatic compareWord(input string what, input usiPkg::usiWord_t got,
		input usiPkg::usiWord_t exp);
		if (got !== exp)
		begin
			errCount++;
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	always @(negedge iSCLK)
	begin
		if (armed)
		begin
			compareWord("oSUsiRd", oSUsiRd, expRd);
			compareWord("oGpioR", 32'(oGpioR), 32'(expPins));
			compareWord("oGpioDir", 32'(oGpioDir), 32'(mDir));
		end
	end

endmodule

// File: list.f
rtl/usiPkg.sv
rtl/gpioPkg.sv
rtl/csrAccessIf.sv
rtl/usiBlockDecode.sv
rtl/gpioCsr.sv
rtl/gpioPinStage.sv
rtl/gpioBlock.sv
bench/gpioChecker.sv
bench/gpioBlockTb.sv

// File: rtl/csrAccessIf.sv
// Decoded register access interface
// Write and read strobes, register offset, write data

`timescale 1ns/1ps

interface csrAccessIf;

	// One-cycle strobes, never both high
	logic write;
	logic read;
	// Register offset of the access
	gpioPkg::csrAdrs_t adrs;
	// Write data, full bus width
	usiPkg::usiWord_t wd;

	// Bus decode side
	modport decode (
		output write, read, adrs, wd
	);

	// Register file side
	modport csr (
		input write, read, adrs, wd
	);

endinterface

// File: rtl/gpioBlock.sv
// GPIO block top level
// Bus decode, register file and pin stage wired through the access interface

`timescale 1ns/1ps

module gpioBlock #(
	parameter usiPkg::usiField_t pBlockAdrs = 8'h01,
	parameter int                pGpioWidth = 16
)(
	// Clock and reset
	input  logic                  iSCLK,
	input  logic                  reset,
	// Slave bus
	input  usiPkg::usiWord_t      iSUsiAdrs,
	input  usiPkg::usiWord_t      iSUsiWd,
	output usiPkg::usiWord_t      oSUsiRd,
	// Pins
	input  logic [pGpioWidth-1:0] iGpioIn,
	input  logic [pGpioWidth-1:0] iGpioAltMode,
	output logic [pGpioWidth-1:0] oGpioR,
	output logic [pGpioWidth-1:0] oGpioDir
);

	// Register file to pin stage
	logic [pGpioWidth-1:0] outCtrl;
	logic [pGpioWidth-1:0] altSel;

	// Decoded access between stage one and two
	csrAccessIf accIf ();

	//--------------------------------------------------------------------------
	// Stages
	//--------------------------------------------------------------------------
	usiBlockDecode #(
		.pBlockAdrs (pBlockAdrs)
	) decode_i (
		.iSCLK     (iSCLK),
		.reset     (reset),
		.iSUsiAdrs (iSUsiAdrs),
		.iSUsiWd   (iSUsiWd),
		.acc       (accIf.decode)
	);

	gpioCsr #(
		.pGpioWidth (pGpioWidth)
	) csr_i (
		.iSCLK    (iSCLK),
		.reset    (reset),
		.acc      (accIf.csr),
		.iGpioIn  (iGpioIn),
		.outCtrl  (outCtrl),
		.altSel   (altSel),
		.oGpioDir (oGpioDir),
		.oSUsiRd  (oSUsiRd)
	);

	gpioPinStage #(
		.pGpioWidth (pGpioWidth)
	) pin_i (
		.iSCLK        (iSCLK),
		.reset        (reset),
		.outCtrl      (outCtrl),
		.altSel       (altSel),
		.iGpioAltMode (iGpioAltMode),
		.oGpioR       (oGpioR)
	);

endmodule

// File: rtl/gpioCsr.sv
// GPIO register file stage
// Output, direction and alternate registers, input synchronizer, read data

`timescale 1ns/1ps

module gpioCsr #(
	parameter int pGpioWidth = 16
)(
	input  logic                  iSCLK,
	input  logic                  reset,
	csrAccessIf.csr               acc,
	input  logic [pGpioWidth-1:0] iGpioIn,
	output logic [pGpioWidth-1:0] outCtrl,
	output logic [pGpioWidth-1:0] altSel,
	output logic [pGpioWidth-1:0] oGpioDir,
	output usiPkg::usiWord_t      oSUsiRd
);

	// One bit per pin
	typedef logic [pGpioWidth-1:0] pinVec_t;

	pinVec_t          outReg;
	pinVec_t          dirReg;
	pinVec_t          altReg;
	pinVec_t          wdPins;
	pinVec_t          inSync1;
	pinVec_t          inSync2;
	pinVec_t          inReg;
	pinVec_t          rdPins;
	usiPkg::usiWord_t rdReg;

	// Upper data bits beyond the pin count are dropped
	assign wdPins = acc.wd[pGpioWidth-1:0];

	//--------------------------------------------------------------------------
	// Control registers
	//--------------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (reset)
		begin
			outReg <= '0;
			dirReg <= '0;
			altReg <= '0;
		end
		else if (acc.write)
		begin
			case (acc.adrs)
				gpioPkg::adrsOut: outReg <= wdPins;
				gpioPkg::adrsDir: dirReg <= wdPins;
				gpioPkg::adrsAlt: altReg <= wdPins;
				// Bitwise modify of the output value
				gpioPkg::adrsSet: outReg <= outReg | wdPins;
				gpioPkg::adrsClr: outReg <= outReg & ~wdPins;
				default:          ;
			endcase
		end
	end

	// Two synchronizer flops, then the input register
	always_ff @(posedge iSCLK)
	begin
		if (reset)
		begin
			inSync1 <= '0;
			inSync2 <= '0;
			inReg   <= '0;
		end
		else
		begin
			inSync1 <= iGpioIn;
			inSync2 <= inSync1;
			inReg   <= inSync2;
		end
	end

	//--------------------------------------------------------------------------
	// Read path
	//--------------------------------------------------------------------------
	// Zero for idle, set/clear and unmapped offsets
	always_comb
	begin
		rdPins = '0;
		if (acc.read)
		begin
			case (acc.adrs)
				gpioPkg::adrsOut: rdPins = outReg;
				gpioPkg::adrsDir: rdPins = dirReg;
				gpioPkg::adrsAlt: rdPins = altReg;
				gpioPkg::adrsIn:  rdPins = inReg;
				default:          rdPins = '0;
			endcase
		end
	end

	// Held one cycle, zero otherwise so slaves can be ORed
	always_ff @(posedge iSCLK)
	begin
		if (reset)
			rdReg <= '0;
		else
			rdReg <= usiPkg::usiWord_t'(rdPins);
	end

	assign outCtrl  = outReg;
	assign altSel   = altReg;
	assign oGpioDir = dirReg;
	assign oSUsiRd  = rdReg;

	// Bus stays quiet unless the decode stage issued a read
	assert property (@(posedge iSCLK) disable iff (reset) !$past(acc.read) |-> (oSUsiRd == '0));

endmodule

// File: rtl/gpioPinStage.sv
// GPIO pin stage
// Per-bit alternate function select and output pin register

`timescale 1ns/1ps

module gpioPinStage #(
	parameter int pGpioWidth = 16
)(
	input  logic                  iSCLK,
	input  logic                  reset,
	input  logic [pGpioWidth-1:0] outCtrl,
	input  logic [pGpioWidth-1:0] altSel,
	input  logic [pGpioWidth-1:0] iGpioAltMode,
	output logic [pGpioWidth-1:0] oGpioR
);

	logic [pGpioWidth-1:0] pinNext;

	//--------------------------------------------------------------------------
	// Pin source select
	//--------------------------------------------------------------------------
	// Alternate source where selected, else software value
	always_comb
	begin
		for (int i = 0; i < pGpioWidth; i++)
		begin
			pinNext[i] = altSel[i] ? iGpioAltMode[i] : outCtrl[i];
		end
	end

	// Output pin register
	always_ff @(posedge iSCLK)
	begin
		if (reset)
			oGpioR <= '0;
		else
			oGpioR <= pinNext;
	end

	// Software-owned pins lag outCtrl by one edge
	assert property (@(posedge iSCLK) disable iff (reset)
		1'b1 |=> (((oGpioR ^ $past(outCtrl)) & ~$past(altSel)) == '0));

endmodule

// File: rtl/gpioPkg.sv
// GPIO register map package
// Register offset type and offsets of the control and status registers

package gpioPkg;

	// Register offset inside the block
	typedef logic [7:0] csrAdrs_t;

	//--------------------------------------------------------------------------
	// Register map
	//--------------------------------------------------------------------------
	// Output value, read/write
	localparam csrAdrs_t adrsOut = 8'h00;
	// Pin direction, 1 drives the pin
	localparam csrAdrs_t adrsDir = 8'h01;
	// Alternate function select per pin
	localparam csrAdrs_t adrsAlt = 8'h02;
	// Synchronized pin input, read only
	localparam csrAdrs_t adrsIn  = 8'h03;
	// Write one to set output bits, reads zero
	localparam csrAdrs_t adrsSet = 8'h04;
	// Write one to clear output bits, reads zero
	localparam csrAdrs_t adrsClr = 8'h05;

	// Offsets above adrsClr are unmapped

endpackage

// File: rtl/usiBlockDecode.sv
// Bus decode stage
// Block address match, command decode, registered access

`timescale 1ns/1ps

module usiBlockDecode #(
	parameter usiPkg::usiField_t pBlockAdrs = 8'h01
)(
	input  logic             iSCLK,
	input  logic             reset,
	input  usiPkg::usiWord_t iSUsiAdrs,
	input  usiPkg::usiWord_t iSUsiWd,
	csrAccessIf.decode       acc
);

	//--------------------------------------------------------------------------
	// Address word fields
	//--------------------------------------------------------------------------
	usiPkg::usiField_t blockField;
	usiPkg::usiField_t activeField;
	gpioPkg::csrAdrs_t offsetField;
	logic              blockHit;

	assign blockField  = iSUsiAdrs[usiPkg::blockMsb:usiPkg::blockLsb];
	assign activeField = iSUsiAdrs[usiPkg::activeMsb:usiPkg::activeLsb];
	assign offsetField = iSUsiAdrs[usiPkg::offsetMsb:usiPkg::offsetLsb];
	// Only our own block address
	assign blockHit    = (blockField == pBlockAdrs);

	// Registered access towards the register file
	always_ff @(posedge iSCLK)
	begin
		if (reset)
		begin
			acc.write <= 1'b0;
			acc.read  <= 1'b0;
			acc.adrs  <= '0;
			acc.wd    <= '0;
		end
		else
		begin
			// Foreign blocks and unknown codes give no strobe
			acc.write <= blockHit && (activeField == usiPkg::cmdWrite);
			acc.read  <= blockHit && (activeField == usiPkg::cmdRead);
			// Offset and data captured next to the strobes
			acc.adrs  <= offsetField;
			acc.wd    <= iSUsiWd;
		end
	end

	// One command per cycle reaches the register file
	assert property (@(posedge iSCLK) disable iff (reset) !(acc.write && acc.read));

endmodule

// File: rtl/usiPkg.sv
// Slave bus package
// Bus word and field types, address word layout, command codes

package usiPkg;

	//--------------------------------------------------------------------------
	// Types
	//--------------------------------------------------------------------------
	// One bus word, address or data
	typedef logic [31:0] usiWord_t;
	// One 8-bit field of the address word
	typedef logic [7:0] usiField_t;

	//--------------------------------------------------------------------------
	// Address word layout, bits 15:8 unused
	//--------------------------------------------------------------------------
	localparam int blockMsb  = 31;
	localparam int blockLsb  = 24;
	localparam int activeMsb = 23;
	localparam int activeLsb = 16;
	localparam int offsetMsb = 7;
	localparam int offsetLsb = 0;

	// Command codes in the active field; anything else counts as idle
	localparam usiField_t cmdIdle  = 8'd0;
	localparam usiField_t cmdWrite = 8'd1;
	localparam usiField_t cmdRead  = 8'd2;

endpackage
